// ==== logic/csr_params.svh ====
// CSR cluster constants: hart count, credit depths, register width, reset values
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

// Number of harts served by the cluster
`define CSR_NUM_HARTS 4

// Request queue depth per hart, also the requester's initial credits per hart
`define CSR_REQ_CREDITS 4

// Response buffer depth per hart inside the merger
`define CSR_RESP_CREDITS 2

// Both credit depths are powers of two so that buffer pointers wrap on their own

`define CSR_XLEN 64

// MPP = 3 (machine mode), MIE and MPIE clear
`define CSR_MSTATUS_RESET 64'h0000_0000_0000_1800

// MXL = 2 (RV64) in the top bits, base ISA bit I set
`define CSR_MISA_VALUE 64'h8000_0000_0000_0100

`endif

// ==== logic/csr_pkg.sv ====
// CSR cluster package: operation encoding, request and response structs, CSR addresses
`include "csr_params.svh"

package csr_pkg;

  localparam int HART_W = $clog2(`CSR_NUM_HARTS);

  typedef enum logic [1:0] {
    CSR_OP_READ        = 2'd0,
    CSR_OP_WRITE       = 2'd1,  // Swap, returns the old value
    CSR_OP_TRAP_ENTER  = 2'd2,  // Returns mtvec
    CSR_OP_TRAP_RETURN = 2'd3   // Returns mepc
  } csr_op_e;

  typedef struct packed {
    csr_op_e              op;
    logic [11:0]          addr;
    logic [`CSR_XLEN-1:0] wdata;
    logic [`CSR_XLEN-1:0] cause;  // Trap entry only
    logic [`CSR_XLEN-1:0] epc;    // Trap entry only
    logic [`CSR_XLEN-1:0] tval;   // Trap entry only
  } csr_req_t;

  typedef struct packed {
    logic [`CSR_XLEN-1:0] data;
    logic                 illegal;
    logic [HART_W-1:0]    hart;
  } csr_resp_t;

  // Machine-mode CSR addresses
  localparam logic [11:0] CSR_MSTATUS   = 12'h300;
  localparam logic [11:0] CSR_MISA      = 12'h301;
  localparam logic [11:0] CSR_MIE       = 12'h304;
  localparam logic [11:0] CSR_MTVEC     = 12'h305;
  localparam logic [11:0] CSR_MSCRATCH  = 12'h340;
  localparam logic [11:0] CSR_MEPC      = 12'h341;
  localparam logic [11:0] CSR_MCAUSE    = 12'h342;
  localparam logic [11:0] CSR_MTVAL     = 12'h343;
  localparam logic [11:0] CSR_MIP       = 12'h344;
  localparam logic [11:0] CSR_MINSTRET  = 12'hb02;
  localparam logic [11:0] CSR_MVENDORID = 12'hf11;
  localparam logic [11:0] CSR_MHARTID   = 12'hf14;

endpackage

// ==== logic/csr_chan_if.sv ====
// Credit-based channel interface with a type-parameterized payload
`timescale 1ns/1ps

interface csr_chan_if #(
  parameter type payload_t = logic
);

  logic     valid;    // Only sent while the sender holds a credit
  payload_t payload;
  logic     credit;   // One-cycle pulse per freed receiver entry

  // Valid is never withdrawn, so there is no ready
  modport sender (
    output valid,
    output payload,
    input  credit
  );

  modport receiver (
    input  valid,
    input  payload,
    output credit
  );

endinterface

// ==== logic/csr_dispatch.sv ====
// Request dispatcher: input register, routing by hart index, request credit return
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_dispatch import csr_pkg::*; (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      req_valid,
  input  logic [HART_W-1:0]         req_hart,
  input  logic [1:0]                req_op,
  input  logic [11:0]               req_addr,
  input  logic [`CSR_XLEN-1:0]      req_wdata,
  input  logic [`CSR_XLEN-1:0]      req_cause,
  input  logic [`CSR_XLEN-1:0]      req_epc,
  input  logic [`CSR_XLEN-1:0]      req_tval,
  output logic [`CSR_NUM_HARTS-1:0] req_credit,
  csr_chan_if.sender                hart_req [`CSR_NUM_HARTS]
);

  localparam int N  = `CSR_NUM_HARTS;
  localparam int CW = $clog2(`CSR_REQ_CREDITS + 1);

  csr_req_t     req_q;        // Shared payload, only the selected hart sees valid
  logic [N-1:0] valid_q;
  logic [N-1:0] hart_credit;

  always_ff @(posedge clk) begin
    if (req_valid) begin
      req_q <= '{op: csr_op_e'(req_op), addr: req_addr, wdata: req_wdata,
                 cause: req_cause, epc: req_epc, tval: req_tval};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q    <= '0;
      req_credit <= '0;
    end else begin
      valid_q <= '0;
      if (req_valid) begin
        valid_q[req_hart] <= 1'b1;
      end
      req_credit <= hart_credit;  // Hand hart credits back one cycle later
    end
  end

  for (genvar i = 0; i < N; i++) begin : g_hart
    logic [CW-1:0] credit_cnt;  // Mirror of the requester's view, for checking only

    assign hart_req[i].valid   = valid_q[i];
    assign hart_req[i].payload = req_q;
    assign hart_credit[i]      = hart_req[i].credit;

    always_ff @(posedge clk) begin
      if (rst) begin
        credit_cnt <= CW'(`CSR_REQ_CREDITS);
      end else begin
        credit_cnt <= credit_cnt + CW'(hart_credit[i]) - CW'(valid_q[i]);
      end
    end

    a_req_has_credit: assert property (@(posedge clk) disable iff (rst)
      valid_q[i] |-> credit_cnt != '0);
  end

  a_hart_in_range: assert property (@(posedge clk) disable iff (rst)
    req_valid |-> int'(req_hart) < N);

endmodule

// ==== logic/csr_hart_file.sv ====
// Per-hart CSR file: request queue, machine-mode registers, operation execution
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_hart_file import csr_pkg::*; #(
  parameter int HART_ID = 0
) (
  input  logic          clk,
  input  logic          rst,
  csr_chan_if.receiver  req,
  csr_chan_if.sender    resp
);

  localparam int XL   = `CSR_XLEN;
  localparam int QD   = `CSR_REQ_CREDITS;
  localparam int QW   = $clog2(QD);
  localparam int QCW  = $clog2(QD + 1);
  localparam int RCW  = $clog2(`CSR_RESP_CREDITS + 1);
  localparam int MIE  = 3;
  localparam int MPIE = 7;
  localparam logic [XL-1:0] MSTATUS_WMASK = 64'h1888;  // MPP, MPIE and MIE

  csr_req_t       q_mem [QD];
  logic [QW-1:0]  q_wr_ptr;
  logic [QW-1:0]  q_rd_ptr;
  logic [QCW-1:0] q_count;
  logic [RCW-1:0] resp_cnt;
  csr_req_t       head;
  logic           exec;
  logic           q_push;
  logic           q_pop;
  logic [XL-1:0]  mstatus, mie, mtvec, mscratch;
  logic [XL-1:0]  mepc, mcause, mtval, mip, minstret;
  logic [XL-1:0]  rd_val;
  logic           known;
  logic           illegal;
  logic           wr_en;
  logic           done_q;
  csr_resp_t      resp_q;

  // An empty queue lets the arriving request execute straight away
  assign head   = (q_count == '0) ? req.payload : q_mem[q_rd_ptr];
  assign exec   = ((q_count != '0) || req.valid) && (resp_cnt != '0);
  assign q_push = req.valid && !(exec && q_count == '0);
  assign q_pop  = exec && (q_count != '0);

  always_ff @(posedge clk) begin
    if (q_push) begin
      q_mem[q_wr_ptr] <= req.payload;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      q_wr_ptr <= '0;
      q_rd_ptr <= '0;
      q_count  <= '0;
      resp_cnt <= RCW'(`CSR_RESP_CREDITS);
    end else begin
      q_wr_ptr <= q_wr_ptr + QW'(q_push);
      q_rd_ptr <= q_rd_ptr + QW'(q_pop);
      q_count  <= q_count + QCW'(q_push) - QCW'(q_pop);
      resp_cnt <= resp_cnt + RCW'(resp.credit) - RCW'(exec);  // Spent at execute time
    end
  end

  always_comb begin
    known  = 1'b1;
    rd_val = '0;
    case (head.addr)
      CSR_MSTATUS:   rd_val = mstatus;
      CSR_MISA:      rd_val = `CSR_MISA_VALUE;
      CSR_MIE:       rd_val = mie;
      CSR_MTVEC:     rd_val = mtvec;
      CSR_MSCRATCH:  rd_val = mscratch;
      CSR_MEPC:      rd_val = mepc;
      CSR_MCAUSE:    rd_val = mcause;
      CSR_MTVAL:     rd_val = mtval;
      CSR_MIP:       rd_val = mip;
      CSR_MINSTRET:  rd_val = minstret;  // Operations done before this one
      CSR_MVENDORID: rd_val = '0;
      CSR_MHARTID:   rd_val = XL'(HART_ID);
      default:       known  = 1'b0;
    endcase
  end

  // Trap ops ignore the address field
  assign illegal = ((head.op == CSR_OP_READ) && !known) ||
                   ((head.op == CSR_OP_WRITE) && (!known || head.addr inside
                     {CSR_MISA, CSR_MVENDORID, CSR_MHARTID, CSR_MINSTRET}));
  assign wr_en   = exec && (head.op == CSR_OP_WRITE) && !illegal;

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus  <= `CSR_MSTATUS_RESET;
      mie      <= '0;
      mtvec    <= '0;
      mscratch <= '0;
      mepc     <= '0;
      mcause   <= '0;
      mtval    <= '0;
      mip      <= '0;
      minstret <= '0;
    end else if (exec) begin
      minstret <= minstret + XL'(1);  // Illegal ops count as completed too
      if (wr_en) begin
        case (head.addr)
          CSR_MSTATUS:  mstatus  <= (mstatus & ~MSTATUS_WMASK) | (head.wdata & MSTATUS_WMASK);
          CSR_MIE:      mie      <= head.wdata;
          CSR_MTVEC:    mtvec    <= head.wdata;
          CSR_MSCRATCH: mscratch <= head.wdata;
          CSR_MEPC:     mepc     <= head.wdata;
          CSR_MCAUSE:   mcause   <= head.wdata;
          CSR_MTVAL:    mtval    <= head.wdata;
          CSR_MIP:      mip      <= head.wdata;
          default:      ;
        endcase
      end
      if (head.op == CSR_OP_TRAP_ENTER) begin
        mepc             <= head.epc;
        mcause           <= head.cause;
        mtval            <= head.tval;
        mstatus[MPIE]    <= mstatus[MIE];
        mstatus[MIE]     <= 1'b0;
        mstatus[12:11]   <= 2'b11;
      end
      if (head.op == CSR_OP_TRAP_RETURN) begin
        mstatus[MIE]  <= mstatus[MPIE];
        mstatus[MPIE] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (exec) begin
      resp_q <= '{data: illegal ? '0 :
                        (head.op == CSR_OP_TRAP_ENTER)  ? mtvec :
                        (head.op == CSR_OP_TRAP_RETURN) ? mepc : rd_val,
                  illegal: illegal, hart: HART_W'(HART_ID)};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      done_q <= 1'b0;
    end else begin
      done_q <= exec;
    end
  end

  assign resp.valid   = done_q;
  assign resp.payload = resp_q;
  assign req.credit   = done_q;  // Queue slot credit goes back with the response

  a_resp_credit_bound: assert property (@(posedge clk) disable iff (rst)
    resp.credit && !exec |-> resp_cnt < RCW'(`CSR_RESP_CREDITS));
  a_queue_not_full: assert property (@(posedge clk) disable iff (rst)
    q_push |-> q_count < QCW'(QD));

endmodule

// ==== logic/csr_resp_merge.sv ====
// Response merger: per-hart response buffers, round-robin output, response credit return
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_resp_merge import csr_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  csr_chan_if.receiver         hart_resp [`CSR_NUM_HARTS],
  output logic                 resp_valid,
  output logic [HART_W-1:0]    resp_hart,
  output logic [`CSR_XLEN-1:0] resp_data,
  output logic                 resp_illegal
);

  localparam int N  = `CSR_NUM_HARTS;
  localparam int D  = `CSR_RESP_CREDITS;
  localparam int PW = $clog2(D);
  localparam int CW = $clog2(D + 1);

  logic [N-1:0]      nonempty;
  logic [N-1:0]      pop;
  csr_resp_t         head [N];
  logic [HART_W-1:0] last_q;     // Previous winner, search starts after it
  logic [HART_W-1:0] grant_idx;
  logic [HART_W-1:0] cand;
  logic              grant_any;
  csr_resp_t         sel_resp;

  for (genvar i = 0; i < N; i++) begin : g_buf
    csr_resp_t     mem [D];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] cnt;
    logic          credit_q;

    always_ff @(posedge clk) begin
      if (hart_resp[i].valid) begin
        mem[wr_ptr] <= hart_resp[i].payload;
      end
    end

    always_ff @(posedge clk) begin
      if (rst) begin
        wr_ptr   <= '0;
        rd_ptr   <= '0;
        cnt      <= '0;
        credit_q <= 1'b0;
      end else begin
        wr_ptr   <= wr_ptr + PW'(hart_resp[i].valid);
        rd_ptr   <= rd_ptr + PW'(pop[i]);
        cnt      <= cnt + CW'(hart_resp[i].valid) - CW'(pop[i]);
        credit_q <= pop[i];  // Entry left, let the hart send again
      end
    end

    assign nonempty[i]         = (cnt != '0);
    assign head[i]             = mem[rd_ptr];
    assign pop[i]              = grant_any && (grant_idx == HART_W'(i));
    assign hart_resp[i].credit = credit_q;

    a_buf_not_full: assert property (@(posedge clk) disable iff (rst)
      hart_resp[i].valid |-> cnt < CW'(D));
  end

  always_comb begin
    grant_any = 1'b0;
    grant_idx = last_q;
    cand      = last_q;
    for (int k = 1; k <= N; k++) begin
      cand = HART_W'((int'(last_q) + k) % N);
      if (!grant_any && nonempty[cand]) begin
        grant_any = 1'b1;
        grant_idx = cand;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      last_q <= HART_W'(N - 1);  // Hart 0 first after reset
    end else if (grant_any) begin
      last_q <= grant_idx;
    end
  end

  assign sel_resp     = head[grant_idx];
  assign resp_valid   = grant_any;
  assign resp_hart    = sel_resp.hart;
  assign resp_data    = sel_resp.data;
  assign resp_illegal = sel_resp.illegal;

endmodule

// ==== logic/csr_cluster_top.sv ====
// CSR cluster top level: dispatcher, per-hart CSR files and response merger
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_cluster_top import csr_pkg::*; (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      req_valid,
  input  logic [HART_W-1:0]         req_hart,
  input  logic [1:0]                req_op,
  input  logic [11:0]               req_addr,
  input  logic [`CSR_XLEN-1:0]      req_wdata,
  input  logic [`CSR_XLEN-1:0]      req_cause,
  input  logic [`CSR_XLEN-1:0]      req_epc,
  input  logic [`CSR_XLEN-1:0]      req_tval,
  output logic [`CSR_NUM_HARTS-1:0] req_credit,
  output logic                      resp_valid,
  output logic [HART_W-1:0]         resp_hart,
  output logic [`CSR_XLEN-1:0]      resp_data,
  output logic                      resp_illegal
);

  // Dispatcher to harts, then harts to merger
  csr_chan_if #(.payload_t(csr_req_t))  req_chan  [`CSR_NUM_HARTS] ();
  csr_chan_if #(.payload_t(csr_resp_t)) resp_chan [`CSR_NUM_HARTS] ();

  csr_dispatch dispatch_i (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req_hart   (req_hart),
    .req_op     (req_op),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .req_cause  (req_cause),
    .req_epc    (req_epc),
    .req_tval   (req_tval),
    .req_credit (req_credit),
    .hart_req   (req_chan)
  );

  for (genvar i = 0; i < `CSR_NUM_HARTS; i++) begin : g_hart
    csr_hart_file #(.HART_ID(i)) hart_i (
      .clk  (clk),
      .rst  (rst),
      .req  (req_chan[i]),
      .resp (resp_chan[i])
    );
  end

  csr_resp_merge merge_i (
    .clk          (clk),
    .rst          (rst),
    .hart_resp    (resp_chan),
    .resp_valid   (resp_valid),
    .resp_hart    (resp_hart),
    .resp_data    (resp_data),
    .resp_illegal (resp_illegal)
  );

endmodule

// ==== verif/csr_tb.sv ====
// CSR cluster testbench: clock, reset, file-driven requests, per-hart expected queues, checks
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_tb import csr_pkg::*; ();

  localparam int N = `CSR_NUM_HARTS;

  typedef struct packed {
    logic [HART_W-1:0]    hart;
    csr_req_t             req;
    logic [`CSR_XLEN-1:0] exp_data;
    logic                 exp_ill;
  } vec_t;

  logic                 clk;
  logic                 rst;
  logic                 req_valid;
  logic [HART_W-1:0]    req_hart;
  logic [1:0]           req_op;
  logic [11:0]          req_addr;
  logic [`CSR_XLEN-1:0] req_wdata, req_cause, req_epc, req_tval;
  logic [N-1:0]         req_credit;
  logic                 resp_valid;
  logic [HART_W-1:0]    resp_hart;
  logic [`CSR_XLEN-1:0] resp_data;
  logic                 resp_illegal;

  vec_t                 vecs [$];
  logic [`CSR_XLEN:0]   exp_q [N][$];  // {illegal, data} in request order
  logic [`CSR_XLEN:0]   exp_head;
  int                   credits [N];
  int                   errors;
  int                   received;
  bit                   loaded;
  logic [31:0]          lcg_state;

  csr_cluster_top dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  // Credit return and response checks on the rising edge
  always @(posedge clk) begin
    if (!rst) begin
      for (int h = 0; h < N; h++) begin
        if (req_credit[h]) credits[h]++;
      end
      if (resp_valid) begin
        if (exp_q[resp_hart].size() == 0) begin
          errors++;
          $display("Unexpected response from hart %0d at %0t ns", resp_hart, $time);
        end else begin
          exp_head = exp_q[resp_hart].pop_front();
          check($sformatf("resp_data[hart %0d]", resp_hart), resp_data, exp_head[63:0]);
          check($sformatf("resp_illegal[hart %0d]", resp_hart), 64'(resp_illegal),
                64'(exp_head[64]));
          received++;
        end
      end
    end
  end

  initial begin
    int    fd;
    int    n;
    int    gap;
    string line;
    logic [63:0] f_hart, f_op, f_addr, f_wdata, f_cause, f_epc, f_tval, f_exp, f_ill;
    vec_t  v;

    lcg_state = 32'h502d;
    errors    = 0;
    received  = 0;
    rst       = 1'b1;
    req_valid = 1'b0;
    req_hart  = '0;
    req_op    = '0;
    req_addr  = '0;
    req_wdata = '0;
    req_cause = '0;
    req_epc   = '0;
    req_tval  = '0;
    for (int h = 0; h < N; h++) credits[h] = `CSR_REQ_CREDITS;

    fd = $fopen("verif/csr_testdata.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Cannot open the test data file verif/csr_testdata.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h", f_hart, f_op, f_addr, f_wdata,
                    f_cause, f_epc, f_tval, f_exp, f_ill);
        if (n == 9) begin
          v.hart      = HART_W'(f_hart);
          v.req.op    = csr_op_e'(f_op[1:0]);
          v.req.addr  = f_addr[11:0];
          v.req.wdata = f_wdata;
          v.req.cause = f_cause;
          v.req.epc   = f_epc;
          v.req.tval  = f_tval;
          v.exp_data  = f_exp;
          v.exp_ill   = f_ill[0];
          vecs.push_back(v);
        end else if (n > 0) begin
          errors++;
          $display("Malformed test data line: %s", line);
        end
      end
      $fclose(fd);
    end
    loaded = 1'b1;

    repeat (3) @(posedge clk);
    #1 rst = 1'b0;

    for (int i = 0; i < vecs.size(); i++) begin
      // Random idle gap only when the target hart changes
      if (i > 0 && vecs[i].hart != vecs[i-1].hart) begin
        gap = int'((next_rand() >> 16) % 32'd4);
        repeat (gap) begin
          @(posedge clk);
          #1;
        end
      end
      while (credits[vecs[i].hart] == 0) begin
        @(posedge clk);
        #1;
      end
      req_valid = 1'b1;
      req_hart  = vecs[i].hart;
      req_op    = vecs[i].req.op;
      req_addr  = vecs[i].req.addr;
      req_wdata = vecs[i].req.wdata;
      req_cause = vecs[i].req.cause;
      req_epc   = vecs[i].req.epc;
      req_tval  = vecs[i].req.tval;
      credits[vecs[i].hart]--;
      exp_q[vecs[i].hart].push_back({vecs[i].exp_ill, vecs[i].exp_data});
      @(posedge clk);
      #1 req_valid = 1'b0;
    end

    wait (received == vecs.size());
    repeat (10) @(posedge clk);  // Room for stray responses and late credits
    for (int h = 0; h < N; h++) begin
      check($sformatf("credits[%0d]", h), 64'(credits[h]), 64'(`CSR_REQ_CREDITS));
    end

    $display("Checked %0d of %0d responses, %0d errors", received, vecs.size(), errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Watchdog allows 20 cycles per operation plus a margin
  initial begin
    wait (loaded);
    repeat (vecs.size() * 20 + 100) @(posedge clk);
    $display("Timeout: only %0d of %0d responses arrived", received, vecs.size());
    for (int h = 0; h < N; h++) begin
      if (exp_q[h].size() != 0) begin
        $display("Hart %0d is missing %0d responses", h, exp_q[h].size());
      end
    end
    $display("Regression failed");
    $finish;
  end

endmodule

// ==== verif/csr_testdata.txt ====
# hart op addr wdata cause epc tval exp_data exp_illegal (all hex)
# op: 0 read, 1 write, 2 trap entry, 3 trap return
0 0 300 0 0 0 0 1800 0
1 0 f14 0 0 0 0 1 0
3 0 f14 0 0 0 0 3 0
0 0 301 0 0 0 0 8000000000000100 0
1 0 300 0 0 0 0 1800 0
0 0 f14 0 0 0 0 0 0
3 0 f11 0 0 0 0 0 0
1 1 301 0 0 0 0 0 1
1 0 301 0 0 0 0 8000000000000100 0
0 0 340 0 0 0 0 0 0
0 1 300 ffffffffffffffff 0 0 0 1800 0
0 0 300 0 0 0 0 1888 0
2 1 340 1 0 0 0 0 0
2 1 340 2 0 0 0 1 0
2 1 340 3 0 0 0 2 0
2 1 340 4 0 0 0 3 0
2 1 340 5 0 0 0 4 0
2 0 340 0 0 0 0 5 0
2 0 b02 0 0 0 0 6 0
2 0 f14 0 0 0 0 2 0
1 1 f14 5 0 0 0 0 1
1 0 7c0 0 0 0 0 0 1
0 1 305 80001000 0 0 0 0 0
3 1 f11 1 0 0 0 0 1
3 1 b02 99 0 0 0 0 1
0 2 0 0 8 80000400 1234 80001000 0
1 1 340 aaaa 0 0 0 0 0
1 0 340 0 0 0 0 aaaa 0
0 0 300 0 0 0 0 1880 0
0 0 341 0 0 0 0 80000400 0
3 0 b02 0 0 0 0 4 0
1 0 b02 0 0 0 0 8 0
0 0 342 0 0 0 0 8 0
0 0 343 0 0 0 0 1234 0
1 2 0 0 2 100 0 0 0
1 3 0 0 0 0 0 100 0
0 3 0 0 0 0 0 80000400 0
1 0 300 0 0 0 0 1880 0
0 0 300 0 0 0 0 1888 0
0 0 b02 0 0 0 0 e 0

// ==== tb.f ====
+incdir+logic
logic/csr_pkg.sv
logic/csr_chan_if.sv
logic/csr_dispatch.sv
logic/csr_hart_file.sv
logic/csr_resp_merge.sv
logic/csr_cluster_top.sv
verif/csr_tb.sv

// ==== Makefile ====
# Verilator flow for the CSR cluster testbench
TOP = csr_tb

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f tb.f -o V$(TOP)

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "Regression passed" sim.log

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f tb.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
